//--- common/mem_pkg.sv
// Word-addressed 16-bit memory bus; one transaction at a time, reads always return a full burst
package mem_pkg;

typedef logic [15:0] addr_t;
typedef logic [15:0] data_t;

// One client request, held stable until its acknowledge
typedef struct packed {
	addr_t addr;
	data_t data;
	logic wr;
} mem_req_t;

// Width of the per-client req, ack and valid vectors
localparam int N_CLIENTS = 3;

// Default read burst length, the top level passes it down
localparam int DEF_BURST = 8;

// Arbiter slots
localparam int fill_id = 0;
localparam int test_id = 1;
localparam int scan_id = 2;

endpackage

//--- common/video_pkg.sv
// Frame coordinates are 8 bits, so frames are limited to 256 x 256 pixels
package video_pkg;

typedef logic [7:0] coord_t;

// RGB565, same width as a memory word
typedef struct packed {
	logic [4:0] r;
	logic [5:0] g;
	logic [4:0] b;
} pixel_t;

// Rectangle in pixels, origin at the top left of the frame
typedef struct packed {
	coord_t x;
	coord_t y;
	coord_t w;
	coord_t h;
} rect_t;

// Position reported with each scanned pixel
typedef struct packed {
	coord_t x;
	coord_t y;
} frame_pos_t;

endpackage

//--- memory/mem_arbiter.sv
// Clients must hold req and their request struct stable until ack; BURST must match mem_array
module mem_arbiter import mem_pkg::*; #(
	parameter int BURST = 8
) (
	input logic CLOCK_50,
	input logic rst,
	input logic [N_CLIENTS - 1:0] req,
	input mem_req_t client_req [N_CLIENTS],
	input logic mem_ack,
	input logic mem_rd_valid,
	input logic mem_busy,
	output logic [N_CLIENTS - 1:0] ack,
	output logic [N_CLIENTS - 1:0] valid,
	output logic mem_go,
	output mem_req_t mem_cmd
);

localparam int IW = $clog2(N_CLIENTS);
localparam int BW = $clog2(BURST + 1);

logic active;
logic found;
logic [IW - 1:0] owner, last, pick;
logic [BW - 1:0] beat;
logic [N_CLIENTS - 1:0] grant;

// Search starts one slot after the last winner
always_comb begin : rotate
	int idx;
	found = 1'b0;
	pick = last;
	for (int i = 1; i <= N_CLIENTS; i++) begin
		idx = (int'(last) + i) % N_CLIENTS;
		if (!found && req[idx]) begin
			found = 1'b1;
			pick = IW'(idx);
		end
	end
end

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		active <= 1'b0;
		mem_go <= 1'b0;
		owner <= '0;
		last <= IW'(N_CLIENTS - 1);
		beat <= '0;
	end else begin
		mem_go <= 1'b0;
		if (!active) begin
			if (found && !mem_busy) begin
				active <= 1'b1;
				owner <= pick;
				last <= pick;
				mem_go <= 1'b1;
				beat <= '0;
			end
		end else if (mem_ack && mem_cmd.wr) begin
			active <= 1'b0;
		end else if (mem_rd_valid) begin
			// Reads keep the memory until the last word
			if (beat == BW'(BURST - 1))
				active <= 1'b0;
			beat <= beat + 1'b1;
		end
	end
end

assign mem_cmd = client_req[owner];
assign grant = active ? N_CLIENTS'(1) << owner : '0;
assign ack = grant & {N_CLIENTS{mem_ack}};
assign valid = grant & {N_CLIENTS{mem_rd_valid}};

// Memory answers only the strobe issued the cycle before
a_ack_after_go: assert property (@(posedge CLOCK_50) disable iff (rst)
	mem_ack |-> $past(mem_go) && active);

// Read data only flows inside a granted read
a_valid_in_read: assert property (@(posedge CLOCK_50) disable iff (rst)
	mem_rd_valid |-> active && !mem_cmd.wr);

// The acknowledge reaches exactly one client that is still requesting
a_ack_to_requester: assert property (@(posedge CLOCK_50) disable iff (rst)
	(ack != '0) |-> $onehot(ack & req));

endmodule

//--- memory/mem_array.sv
// Behavioural model of the full 64K-word space, zeroed during reset; READ_LAT must be at least 1
module mem_array import mem_pkg::*; #(
	parameter int BURST = 8,
	parameter int READ_LAT = 3
) (
	input logic CLOCK_50,
	input logic rst,
	input logic go,
	input mem_req_t cmd,
	output logic ack,
	output logic busy,
	output logic rd_valid,
	output data_t rd_data
);

localparam int DEPTH = 2 ** $bits(addr_t);
localparam int LW = $clog2(READ_LAT + 1);
localparam int BW = $clog2(BURST + 1);

data_t mem [DEPTH];
addr_t rd_addr;
logic wr_q;
logic [LW - 1:0] lat_cnt;
logic [BW - 1:0] beat_cnt;

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] <= '0;
		ack <= 1'b0;
		busy <= 1'b0;
		rd_valid <= 1'b0;
		wr_q <= 1'b0;
		lat_cnt <= '0;
		beat_cnt <= '0;
	end else begin
		ack <= go;
		rd_valid <= 1'b0;
		if (go) begin
			busy <= 1'b1;
			wr_q <= cmd.wr;
			rd_addr <= cmd.addr;
			// Write lands on the same edge that raises ack
			if (cmd.wr)
				mem[cmd.addr] <= cmd.data;
			else
				lat_cnt <= LW'(READ_LAT);
		end else if ((ack && wr_q) || (rd_valid && beat_cnt == '0)) begin
			busy <= 1'b0;
		end

		if (lat_cnt != '0)
			lat_cnt <= lat_cnt - 1'b1;

		// First word when the latency runs out, then one per cycle
		if (lat_cnt == LW'(1) || beat_cnt != '0) begin
			rd_valid <= 1'b1;
			rd_data <= mem[rd_addr];
			rd_addr <= rd_addr + 1'b1;
			beat_cnt <= (lat_cnt == LW'(1)) ? BW'(BURST - 1) : beat_cnt - 1'b1;
		end
	end
end

// Arbiter must wait for the previous transaction
a_no_go_while_busy: assert property (@(posedge CLOCK_50) disable iff (rst)
	go |-> !busy);

endmodule

//--- rtl/frame_mem_top.sv
// Single clock; test region must stay outside the frame, fill rectangle inside it
module frame_mem_top import mem_pkg::*, video_pkg::*; #(
	parameter int BURST = DEF_BURST,
	parameter int READ_LAT = 3,
	parameter addr_t FRAME_BASE = 16'h1000,
	parameter int FRAME_W = 16,
	parameter int FRAME_H = 8,
	parameter rect_t FILL_RECT = '{x: 8'd3, y: 8'd2, w: 8'd6, h: 8'd4},
	parameter pixel_t FILL_COLOR = '{r: 5'h1f, g: 6'h10, b: 5'h04},
	parameter addr_t TEST_BASE = 16'h2000,
	parameter int TEST_LEN = 64
) (
	input logic CLOCK_50,
	input logic rst,
	input logic fill_start,
	input logic test_start,
	input logic scan_en,
	output logic fill_active,
	output logic test_done,
	output logic test_fail,
	output pixel_t pixel,
	output frame_pos_t pos,
	output logic pixel_valid,
	output logic frame_start
);

logic [N_CLIENTS - 1:0] req, ack, valid;
mem_req_t client_req [N_CLIENTS];
mem_req_t mem_cmd;
logic mem_go, mem_ack, mem_busy, mem_rd_valid;
data_t rd_data;

// Clients
rect_fill #(.FRAME_BASE(FRAME_BASE), .FRAME_W(FRAME_W), .FRAME_H(FRAME_H),
	.FILL_RECT(FILL_RECT), .FILL_COLOR(FILL_COLOR)) i_rect_fill (
	.CLOCK_50(CLOCK_50), .rst(rst), .fill_start(fill_start), .ack(ack[fill_id]),
	.req(req[fill_id]), .cmd(client_req[fill_id]), .fill_active(fill_active));

mem_test #(.BURST(BURST), .TEST_BASE(TEST_BASE), .TEST_LEN(TEST_LEN)) i_mem_test (
	.CLOCK_50(CLOCK_50), .rst(rst), .test_start(test_start), .ack(ack[test_id]),
	.valid(valid[test_id]), .rd_data(rd_data), .req(req[test_id]),
	.cmd(client_req[test_id]), .test_done(test_done), .test_fail(test_fail));

scan_out #(.BURST(BURST), .FRAME_BASE(FRAME_BASE), .FRAME_W(FRAME_W),
	.FRAME_H(FRAME_H)) i_scan_out (
	.CLOCK_50(CLOCK_50), .rst(rst), .scan_en(scan_en), .ack(ack[scan_id]),
	.valid(valid[scan_id]), .rd_data(rd_data), .req(req[scan_id]),
	.cmd(client_req[scan_id]), .pixel(pixel), .pos(pos),
	.pixel_valid(pixel_valid), .frame_start(frame_start));

// Shared memory
mem_arbiter #(.BURST(BURST)) i_mem_arbiter (
	.CLOCK_50(CLOCK_50), .rst(rst), .req(req), .client_req(client_req),
	.mem_ack(mem_ack), .mem_rd_valid(mem_rd_valid), .mem_busy(mem_busy),
	.ack(ack), .valid(valid), .mem_go(mem_go), .mem_cmd(mem_cmd));

mem_array #(.BURST(BURST), .READ_LAT(READ_LAT)) i_mem_array (
	.CLOCK_50(CLOCK_50), .rst(rst), .go(mem_go), .cmd(mem_cmd),
	.ack(mem_ack), .busy(mem_busy), .rd_valid(mem_rd_valid), .rd_data(rd_data));

endmodule

//--- rtl/mem_test.sv
// TEST_LEN must be a multiple of BURST; test_fail and test_done clear only on the next start
module mem_test import mem_pkg::*; #(
	parameter int BURST = 8,
	parameter addr_t TEST_BASE = 16'h2000,
	parameter int TEST_LEN = 64
) (
	input logic CLOCK_50,
	input logic rst,
	input logic test_start,
	input logic ack,
	input logic valid,
	input data_t rd_data,
	output logic req,
	output mem_req_t cmd,
	output logic test_done,
	output logic test_fail
);

localparam int BW = $clog2(BURST + 1);

typedef enum logic [1:0] {st_idle, st_write, st_rd_req, st_rd_data} state_t;

state_t state;
addr_t offs;
addr_t cur_addr;
logic [BW - 1:0] beat;

// Pattern is the address with its bytes swapped
function automatic data_t pattern(input addr_t a);
	return {a[7:0], a[15:8]};
endfunction

assign cur_addr = TEST_BASE + offs;
assign req = (state == st_write) || (state == st_rd_req);
assign cmd = '{addr: cur_addr, data: pattern(cur_addr), wr: state == st_write};

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= st_idle;
		offs <= '0;
		beat <= '0;
		test_done <= 1'b0;
		test_fail <= 1'b0;
	end else begin
		case (state)
		st_idle: if (test_start) begin
			offs <= '0;
			beat <= '0;
			test_done <= 1'b0;
			test_fail <= 1'b0;
			state <= st_write;
		end
		st_write: if (ack) begin
			if (int'(offs) == TEST_LEN - 1) begin
				offs <= '0;
				state <= st_rd_req;
			end else begin
				offs <= offs + 1'b1;
			end
		end
		st_rd_req: if (ack)
			state <= st_rd_data;
		st_rd_data: if (valid) begin
			// Burst base plus beat gives the word address
			if (rd_data != pattern(cur_addr + addr_t'(beat)))
				test_fail <= 1'b1;
			if (beat == BW'(BURST - 1)) begin
				beat <= '0;
				if (int'(offs) + BURST >= TEST_LEN) begin
					test_done <= 1'b1;
					state <= st_idle;
				end else begin
					offs <= offs + addr_t'(BURST);
					state <= st_rd_req;
				end
			end else begin
				beat <= beat + 1'b1;
			end
		end
		default: state <= st_idle;
		endcase
	end
end

endmodule

//--- rtl/rect_fill.sv
// Rectangle is clipped to the frame; one write per acknowledge, fill_start ignored while active
module rect_fill import mem_pkg::*, video_pkg::*; #(
	parameter addr_t FRAME_BASE = 16'h1000,
	parameter int FRAME_W = 16,
	parameter int FRAME_H = 8,
	parameter rect_t FILL_RECT = '{x: 8'd0, y: 8'd0, w: 8'd1, h: 8'd1},
	parameter pixel_t FILL_COLOR = '0
) (
	input logic CLOCK_50,
	input logic rst,
	input logic fill_start,
	input logic ack,
	output logic req,
	output mem_req_t cmd,
	output logic fill_active
);

// Exclusive end column and row after clipping
localparam int X_END = (int'(FILL_RECT.x) + int'(FILL_RECT.w) > FRAME_W) ?
	FRAME_W : int'(FILL_RECT.x) + int'(FILL_RECT.w);
localparam int Y_END = (int'(FILL_RECT.y) + int'(FILL_RECT.h) > FRAME_H) ?
	FRAME_H : int'(FILL_RECT.y) + int'(FILL_RECT.h);
localparam bit EMPTY = (X_END <= int'(FILL_RECT.x)) || (Y_END <= int'(FILL_RECT.y));

coord_t col, row;

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		fill_active <= 1'b0;
		col <= '0;
		row <= '0;
	end else if (!fill_active) begin
		if (fill_start && !EMPTY) begin
			fill_active <= 1'b1;
			col <= FILL_RECT.x;
			row <= FILL_RECT.y;
		end
	end else if (ack) begin
		if (int'(col) == X_END - 1) begin
			col <= FILL_RECT.x;
			// Last column of the last row ends the fill
			if (int'(row) == Y_END - 1)
				fill_active <= 1'b0;
			else
				row <= row + 1'b1;
		end else begin
			col <= col + 1'b1;
		end
	end
end

assign req = fill_active;
assign cmd = '{
	addr: addr_t'(int'(FRAME_BASE) + int'(row) * FRAME_W + int'(col)),
	data: data_t'(FILL_COLOR),
	wr: 1'b1
};

endmodule

//--- rtl/scan_out.sv
// FRAME_W must be a multiple of BURST; position is kept while scan_en is low
module scan_out import mem_pkg::*, video_pkg::*; #(
	parameter int BURST = 8,
	parameter addr_t FRAME_BASE = 16'h1000,
	parameter int FRAME_W = 16,
	parameter int FRAME_H = 8
) (
	input logic CLOCK_50,
	input logic rst,
	input logic scan_en,
	input logic ack,
	input logic valid,
	input data_t rd_data,
	output logic req,
	output mem_req_t cmd,
	output pixel_t pixel,
	output frame_pos_t pos,
	output logic pixel_valid,
	output logic frame_start
);

localparam int DEPTH = 2 * BURST;
localparam int PW = $clog2(DEPTH);
localparam int CW = $clog2(DEPTH + 1);
localparam int BW = $clog2(BURST + 1);
localparam int FRAME_WORDS = FRAME_W * FRAME_H;

pixel_t line_buf [DEPTH];
logic [PW - 1:0] wr_ptr, rd_ptr;
logic [CW - 1:0] count;
logic [BW - 1:0] beat;
logic in_flight;
logic pop;
addr_t fetch_offs;
coord_t x, y;

assign pop = scan_en && count != '0;
assign cmd = '{addr: FRAME_BASE + fetch_offs, data: '0, wr: 1'b0};

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		req <= 1'b0;
		in_flight <= 1'b0;
		beat <= '0;
		fetch_offs <= '0;
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
		x <= '0;
		y <= '0;
		pixel_valid <= 1'b0;
		frame_start <= 1'b0;
	end else begin
		// Ask for a burst once the buffer has room for one
		if (!req && !in_flight && scan_en && count <= CW'(BURST)) begin
			req <= 1'b1;
		end else if (ack) begin
			req <= 1'b0;
			in_flight <= 1'b1;
			fetch_offs <= (int'(fetch_offs) + BURST >= FRAME_WORDS) ?
				'0 : fetch_offs + addr_t'(BURST);
		end

		if (valid) begin
			wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			beat <= (beat == BW'(BURST - 1)) ? '0 : beat + 1'b1;
			if (beat == BW'(BURST - 1))
				in_flight <= 1'b0;
		end

		count <= count + CW'(valid) - CW'(pop);
		pixel_valid <= pop;
		frame_start <= pop && x == '0 && y == '0;

		// Row-major walk over the frame
		if (pop) begin
			rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (int'(x) == FRAME_W - 1) begin
				x <= '0;
				y <= (int'(y) == FRAME_H - 1) ? '0 : y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end
end

always_ff @(posedge CLOCK_50) begin
	if (valid)
		line_buf[wr_ptr] <= pixel_t'(rd_data);
	if (pop) begin
		pixel <= line_buf[rd_ptr];
		pos <= '{x: x, y: y};
	end
end

// Arbiter delivers only words this client asked for
a_no_overflow: assert property (@(posedge CLOCK_50) disable iff (rst)
	valid |-> in_flight && count < CW'(DEPTH));

endmodule

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; the exit status is the test result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module frame_mem_tb -Mdir obj_dir &&
./obj_dir/Vframe_mem_tb || exit 1

//--- verification/frame_mem_tb.sv
// Frame checks assume the fill rectangle lies inside the frame and the test region outside it
module frame_mem_tb import mem_pkg::*, video_pkg::*; ();

localparam int BURST = 8;
localparam int READ_LAT = 3;
localparam int FRAME_W = 16;
localparam int FRAME_H = 8;
localparam int TEST_LEN = 64;
localparam rect_t FILL_RECT = '{x: 8'd5, y: 8'd1, w: 8'd7, h: 8'd5};
localparam pixel_t FILL_COLOR = '{r: 5'h03, g: 6'h2a, b: 5'h11};
localparam int FILL_WORDS = int'(FILL_RECT.w) * int'(FILL_RECT.h);
// Worst case per transaction is two foreign read bursts ahead of our own
localparam int TXN_CYCLES = 3 * (2 + READ_LAT + BURST);
localparam int TXNS = 2 * FILL_WORDS + 2 * (TEST_LEN + TEST_LEN / BURST) +
	12 * FRAME_W * FRAME_H / BURST;
localparam int MAX_CYCLES = TXNS * TXN_CYCLES + 500;

logic CLOCK_50, rst, fill_start, test_start, scan_en;
logic fill_active, test_done, test_fail, pixel_valid, frame_start;
pixel_t pixel;
frame_pos_t pos;

integer seed;
int cycles = 0;
int fill_writes, fills_done;
logic idle_phase, fill_q, frame_ok, chk;
logic [1:0] quiet;
coord_t exp_x, exp_y;
pixel_t exp_pix;
pixel_t model [FRAME_W * FRAME_H];

frame_mem_top #(.BURST(BURST), .READ_LAT(READ_LAT), .FRAME_W(FRAME_W), .FRAME_H(FRAME_H),
	.FILL_RECT(FILL_RECT), .FILL_COLOR(FILL_COLOR), .TEST_LEN(TEST_LEN)) i_frame_mem_top (
	.CLOCK_50(CLOCK_50), .rst(rst), .fill_start(fill_start), .test_start(test_start),
	.scan_en(scan_en), .fill_active(fill_active), .test_done(test_done),
	.test_fail(test_fail), .pixel(pixel), .pos(pos), .pixel_valid(pixel_valid),
	.frame_start(frame_start));

function automatic logic in_rect(input int col, input int row);
	return col >= int'(FILL_RECT.x) && col < int'(FILL_RECT.x) + int'(FILL_RECT.w) &&
		row >= int'(FILL_RECT.y) && row < int'(FILL_RECT.y) + int'(FILL_RECT.h);
endfunction

task automatic stop_run(input string msg);
	$display("ERROR at time %0t: %s", $time, msg);
	$display("Test failures found");
	$fatal(1);
endtask

task automatic wait_gap();
	int n;
	n = 2 + int'($unsigned($random(seed)) % 16);
	repeat (n) @(posedge CLOCK_50);
endtask

task automatic wait_frames(input int n);
	repeat (n) @(posedge CLOCK_50 iff frame_start);
endtask

initial begin
	CLOCK_50 = 1'b0;
	forever #50 CLOCK_50 = ~CLOCK_50;
end

// Reference frame, updated once each fill has finished
always @(posedge CLOCK_50) begin
	if (rst) begin
		for (int i = 0; i < FRAME_W * FRAME_H; i++)
			model[i] <= '0;
		fill_q <= 1'b0;
		fills_done <= 0;
	end else begin
		fill_q <= fill_active;
		if (fill_q && !fill_active) begin
			fills_done <= fills_done + 1;
			for (int i = 0; i < FRAME_W * FRAME_H; i++)
				if (in_rect(i % FRAME_W, i / FRAME_W))
					model[i] <= FILL_COLOR;
		end
	end
end

// Only frames fetched entirely after the last fill are compared
assign chk = !fill_active && (frame_start ? quiet != 2'd0 : frame_ok);
assign exp_pix = model[int'(exp_y) * FRAME_W + int'(exp_x)];

always @(posedge CLOCK_50) begin
	if (rst) begin
		exp_x <= '0;
		exp_y <= '0;
		quiet <= 2'd2;
		frame_ok <= 1'b1;
	end else begin
		frame_ok <= chk;
		if (fill_active)
			quiet <= 2'd0;
		else if (frame_start && quiet != 2'd2)
			quiet <= quiet + 2'd1;
		// Expected raster position of the next pixel
		if (pixel_valid) begin
			if (int'(exp_x) == FRAME_W - 1) begin
				exp_x <= '0;
				exp_y <= (int'(exp_y) == FRAME_H - 1) ? '0 : exp_y + 8'd1;
			end else begin
				exp_x <= exp_x + 8'd1;
			end
		end
	end
end

// Fill writes seen at the arbiter, restarted by an accepted start
always @(posedge CLOCK_50) begin
	if (rst)
		fill_writes <= 0;
	else if (fill_start && !fill_active)
		fill_writes <= 0;
	else if (i_frame_mem_top.ack[fill_id])
		fill_writes <= fill_writes + 1;
end

always @(posedge CLOCK_50) begin
	cycles <= cycles + 1;
	if (cycles >= MAX_CYCLES) begin
		$display("Test failures found");
		$fatal(1, "Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
	end
end

a_idle_after_reset: assert property (@(posedge CLOCK_50) disable iff (rst)
	idle_phase |-> !fill_active && !test_done && !test_fail && !pixel_valid)
	else stop_run("status output active before any start");

a_pos_order: assert property (@(posedge CLOCK_50) disable iff (rst)
	pixel_valid |-> pos.x == exp_x && pos.y == exp_y)
	else stop_run($sformatf("pos (%0d,%0d), expected (%0d,%0d)", $sampled(pos.x),
		$sampled(pos.y), $sampled(exp_x), $sampled(exp_y)));

a_frame_start_origin: assert property (@(posedge CLOCK_50) disable iff (rst)
	frame_start |-> pixel_valid && pos.x == '0 && pos.y == '0)
	else stop_run("frame_start away from pixel (0,0)");

a_origin_marked: assert property (@(posedge CLOCK_50) disable iff (rst)
	pixel_valid && exp_x == '0 && exp_y == '0 |-> frame_start)
	else stop_run("pixel (0,0) without frame_start");

a_pixel_value: assert property (@(posedge CLOCK_50) disable iff (rst)
	pixel_valid && chk |-> pixel == exp_pix)
	else stop_run($sformatf("pixel at (%0d,%0d) is %h, expected %h", $sampled(exp_x),
		$sampled(exp_y), $sampled(pixel), $sampled(exp_pix)));

a_fill_starts: assert property (@(posedge CLOCK_50) disable iff (rst)
	fill_start && !fill_active |=> fill_active)
	else stop_run("fill_active did not rise after fill_start");

a_fill_writes: assert property (@(posedge CLOCK_50) disable iff (rst)
	$fell(fill_active) |-> fill_writes == FILL_WORDS)
	else stop_run($sformatf("fill ended after %0d writes, expected %0d",
		$sampled(fill_writes), FILL_WORDS));

a_test_clean: assert property (@(posedge CLOCK_50) disable iff (rst)
	test_done |-> !test_fail)
	else stop_run("test_fail set at test_done");

initial begin
	seed = 32'h1a87;
	rst = 1'b1;
	fill_start = 1'b0;
	test_start = 1'b0;
	scan_en = 1'b0;
	idle_phase = 1'b1;
	repeat (2) @(posedge CLOCK_50);
	rst <= 1'b0;
	wait_gap();

	// Empty frame buffer
	idle_phase <= 1'b0;
	scan_en <= 1'b1;
	wait_frames(2);

	// Fill, with a second start while busy
	fill_start <= 1'b1;
	@(posedge CLOCK_50);
	fill_start <= 1'b0;
	@(posedge CLOCK_50 iff fill_active);
	wait_gap();
	fill_start <= 1'b1;
	@(posedge CLOCK_50);
	fill_start <= 1'b0;
	@(posedge CLOCK_50 iff !fill_active);
	wait_frames(3);

	// Self-test alone
	wait_gap();
	test_start <= 1'b1;
	@(posedge CLOCK_50);
	test_start <= 1'b0;
	@(posedge CLOCK_50 iff test_done);
	wait_frames(2);

	// All three clients at once
	wait_gap();
	fill_start <= 1'b1;
	test_start <= 1'b1;
	@(posedge CLOCK_50);
	fill_start <= 1'b0;
	test_start <= 1'b0;
	@(posedge CLOCK_50 iff fill_active);
	@(posedge CLOCK_50 iff !fill_active);
	@(posedge CLOCK_50 iff test_done);
	wait_frames(3);

	if (fills_done == 2) begin
		$display("All tests passed!");
		$finish;
	end else begin
		stop_run($sformatf("fill finished %0d times, expected 2", fills_done));
	end
end

endmodule

//--- vlog.f
common/mem_pkg.sv
common/video_pkg.sv
memory/mem_array.sv
memory/mem_arbiter.sv
rtl/rect_fill.sv
rtl/mem_test.sv
rtl/scan_out.sv
rtl/frame_mem_top.sv
verification/frame_mem_tb.sv
